// File: list.f
source/gem_link_pkg.sv
source/gbt_frame_decoder.sv
source/ctrl_reg_bank.sv
source/reply_frame_encoder.sv
source/gem_ctrl_top.sv
tests/gem_ctrl_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the gem_ctrl_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module gem_ctrl_top_tb -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vgem_ctrl_top_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Verification passed" <<< "$sim_out"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

// File: tests/gem_ctrl_top_tb.sv
`timescale 1ns/1ps

module gem_ctrl_top_tb;

  localparam int TBL_LEN      = 13;
  localparam int NUM_REGS     = 16; // DUT default, used for the model
  localparam int WATCHDOG_CYC = TBL_LEN * 20 + 50;

  logic                    clk40;
  logic                    arst_n_i;
  gem_link_pkg::gbt_word_t gbt_word_i;
  logic                    rsp_valid_o;
  gem_link_pkg::payload_t  rsp_word_o;

  // request table, one row per frame
  logic        tbl_valid [TBL_LEN];
  logic        tbl_we    [TBL_LEN];
  logic [15:0] tbl_addr  [TBL_LEN];
  logic [31:0] tbl_data  [TBL_LEN];
  int          tbl_idle  [TBL_LEN]; // idle words before the frame
  logic        tbl_has2a [TBL_LEN]; // frame carries a 0x2A group

  logic [31:0] model_regs [NUM_REGS];
  int          cyc = 0;
  int          val_errs;
  int          proto_errs;
  int          exp_cyc    [$]; // cycle the tenth word was driven
  int          exp_idx    [$];
  logic [5:0]  exp_status [$];
  logic [31:0] exp_data   [$];

  gem_ctrl_top gem_ctrl_top_inst (
    .clk40       (clk40),
    .arst_n_i    (arst_n_i),
    .gbt_word_i  (gbt_word_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_word_o  (rsp_word_o)
  );

  initial begin
    clk40 = 1'b0;
    forever #4 clk40 = ~clk40; // 8 ns
  end

  always @(posedge clk40) cyc <= cyc + 1;

  // --------------------------------------------------
  // table and reference model
  // --------------------------------------------------

  task automatic add_entry(input int i, input logic v, input logic we, input logic [15:0] a,
                           input logic [31:0] d, input int idle, input logic has2a);
    tbl_valid[i] = v;
    tbl_we[i]    = we;
    tbl_addr[i]  = a;
    tbl_data[i]  = d;
    tbl_idle[i]  = idle;
    tbl_has2a[i] = has2a;
  endtask

  task automatic load_table();
    //        idx vld we  addr      data          idle 2a
    add_entry(0,  1, 1, 16'h0003, 32'hDEAD_BEEF, 0, 0);
    add_entry(1,  1, 1, 16'h000F, 32'h12A8_55C3, 2, 1); // 0x2A in data[23:18]
    add_entry(2,  1, 0, 16'h0003, 32'h0000_0000, 1, 0);
    add_entry(3,  1, 0, 16'h000F, 32'h0000_0000, 0, 0);
    add_entry(4,  1, 0, 16'h0007, 32'h0000_0000, 3, 0); // never written
    add_entry(5,  1, 1, 16'h0010, 32'hFFFF_FFFF, 1, 0); // first bad address
    add_entry(6,  1, 1, 16'hA812, 32'h0BAD_F00D, 0, 1); // 0x2A in address
    add_entry(7,  1, 0, 16'h0000, 32'h0000_0000, 2, 0); // no wrap onto reg 0
    add_entry(8,  0, 1, 16'h0005, 32'h1111_1111, 1, 0); // dropped frame
    add_entry(9,  1, 0, 16'h0002, 32'h0000_0000, 0, 0);
    add_entry(10, 1, 0, 16'h0005, 32'h0000_0000, 2, 0); // dropped write absent
    add_entry(11, 1, 1, 16'h0001, 32'hA5A5_0F0F, 3, 0);
    add_entry(12, 1, 0, 16'h0001, 32'h0000_0000, 1, 0);
  endtask

  // status and data a reply should carry, model updated on good writes
  task automatic predict(input int i);
    logic       in_range;
    logic [5:0] st;
    logic [31:0] dt;
    in_range = tbl_addr[i] < 16'(NUM_REGS);
    st       = 6'b10_0000;               // ack
    st[4]    = tbl_we[i];
    st[3]    = ~in_range;
    if (!in_range) dt = 32'h0;
    else if (tbl_we[i]) begin
      dt = tbl_data[i];
      model_regs[tbl_addr[i][3:0]] = tbl_data[i];
    end else dt = model_regs[tbl_addr[i][3:0]];
    exp_cyc.push_back(cyc);
    exp_idx.push_back(i);
    exp_status.push_back(st);
    exp_data.push_back(dt);
  endtask

  function automatic logic [5:0] reply_word(input logic [5:0] st, input logic [31:0] d,
                                            input int w);
    case (w)
      0:       return 6'h2A;
      1:       return {st[5:2], d[31:30]}; // status top, data msbs
      2:       return d[29:24];
      3:       return d[23:18];
      4:       return d[17:12];
      5:       return d[11:6];
      default: return d[5:0];
    endcase
  endfunction

  function automatic logic frame_has_2a(input logic [47:0] field);
    for (int k = 0; k < 8; k++) begin
      if (field[47 - 6*k -: 6] == 6'h2A) return 1'b1;
    end
    return 1'b0;
  endfunction

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  // random flags on every word
  task automatic drive_word(input logic [5:0] p);
    @(posedge clk40);
    #1;
    gbt_word_i = {4'($urandom), p};
  endtask

  function automatic logic [5:0] idle_payload();
    logic [5:0] p;
    p = 6'($urandom);
    while (p == 6'h2A) p = 6'($urandom); // must not look like a start
    return p;
  endfunction

  task automatic send_frame(input int i);
    logic [47:0] field;
    field = {tbl_addr[i], tbl_data[i]};
    if (tbl_has2a[i] != frame_has_2a(field)) begin
      $display("table entry %0d has a wrong 0x2A group flag", i);
      proto_errs++;
    end
    drive_word(6'h2A);
    drive_word({tbl_valid[i], tbl_we[i], 4'b0000}); // begin word
    for (int k = 0; k < 8; k++) drive_word(field[47 - 6*k -: 6]);
    if (tbl_valid[i]) predict(i);
  endtask

  initial begin : main_seq
    void'($urandom(32'h2644_50bd));
    arst_n_i   = 1'b0;
    gbt_word_i = '0;
    val_errs   = 0;
    proto_errs = 0;
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = 32'h0;
    load_table();
    repeat (3) @(posedge clk40);
    #1;
    arst_n_i = 1'b1;
    if (rsp_valid_o !== 1'b0 || rsp_word_o !== 6'h00) begin
      $display("reply outputs not idle after reset");
      proto_errs++;
    end
    for (int i = 0; i < TBL_LEN; i++) begin
      repeat (tbl_idle[i]) drive_word(idle_payload());
      send_frame(i);
    end
    repeat (12) drive_word(idle_payload()); // let the last reply drain
    if (exp_cyc.size() != 0) begin
      $display("%0d replies still outstanding at end of run", exp_cyc.size());
      proto_errs++;
    end
    $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

  // --------------------------------------------------
  // reply checker
  // --------------------------------------------------

  initial begin : reply_check
    logic       have;
    logic [5:0] st;
    logic [5:0] want;
    logic [31:0] dt;
    int         start;
    int         idx;
    @(posedge arst_n_i);
    forever begin
      @(posedge clk40);
      #1;
      if (rsp_valid_o) begin
        have = exp_cyc.size() > 0;
        st   = 6'h0;
        dt   = 32'h0;
        idx  = -1;
        if (!have) begin
          $display("%0t: reply frame arrived with no request pending", $time);
          proto_errs++;
        end else begin
          start = exp_cyc.pop_front();
          idx   = exp_idx.pop_front();
          st    = exp_status.pop_front();
          dt    = exp_data.pop_front();
          if (cyc != start + 3) begin // 3 edges after tenth word
            $display("ERR t=%0t rsp_valid_o start cycle exp=%0d got=%0d",
                     $time, start + 3, cyc);
            val_errs++;
          end
        end
        for (int w = 0; w < 7; w++) begin
          if (w > 0) begin
            @(posedge clk40);
            #1;
          end
          want = reply_word(st, dt, w);
          if (!rsp_valid_o) begin
            $display("%0t: reply for entry %0d ended after %0d words", $time, idx, w);
            proto_errs++;
          end else if (have && rsp_word_o != want) begin
            $display("ERR t=%0t rsp_word_o entry %0d word %0d exp=%h got=%h",
                     $time, idx, w, want, rsp_word_o);
            val_errs++;
          end
        end
        @(posedge clk40);
        #1;
        if (rsp_valid_o) begin
          $display("%0t: rsp_valid_o high for more than 7 cycles", $time);
          proto_errs++;
        end else if (rsp_word_o != 6'h00) begin // first idle cycle after a frame
          $display("ERR t=%0t rsp_word_o exp=%h got=%h", $time, 6'h00, rsp_word_o);
          val_errs++;
        end
      end else begin
        if (rsp_word_o != 6'h00) begin // idle must be zero
          $display("ERR t=%0t rsp_word_o exp=%h got=%h", $time, 6'h00, rsp_word_o);
          val_errs++;
        end
        if (exp_cyc.size() > 0 && cyc > exp_cyc[0] + 3) begin
          $display("%0t: no reply for table entry %0d", $time, exp_idx[0]);
          proto_errs++;
          void'(exp_cyc.pop_front());
          void'(exp_idx.pop_front());
          void'(exp_status.pop_front());
          void'(exp_data.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk40);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYC);
    $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: source/gem_ctrl_top.sv
`timescale 1ns/1ps

module gem_ctrl_top #(
  parameter int NUM_REGS = 16 // 1 to 65536
) (
  input  logic                    clk40,
  input  logic                    arst_n_i,
  input  gem_link_pkg::gbt_word_t gbt_word_i,
  output logic                    rsp_valid_o,
  output gem_link_pkg::payload_t  rsp_word_o
);

  // --------------------------------------------------
  // decoder to register bank
  // --------------------------------------------------

  logic                    req_stb;
  logic                    req_we;
  gem_link_pkg::reg_addr_t req_addr;
  gem_link_pkg::reg_data_t req_data;

  // register bank to encoder
  logic                    rsp_stb;
  gem_link_pkg::payload_t  rsp_status;
  gem_link_pkg::reg_data_t rsp_data;

  gbt_frame_decoder gbt_frame_decoder_inst (
    .clk40      (clk40),
    .arst_n_i   (arst_n_i),
    .gbt_word_i (gbt_word_i),
    .req_stb_o  (req_stb),
    .req_we_o   (req_we),
    .req_addr_o (req_addr),
    .req_data_o (req_data)
  );

  ctrl_reg_bank #(
    .NUM_REGS (NUM_REGS)
  ) ctrl_reg_bank_inst (
    .clk40        (clk40),
    .arst_n_i     (arst_n_i),
    .req_stb_i    (req_stb),
    .req_we_i     (req_we),
    .req_addr_i   (req_addr),
    .req_data_i   (req_data),
    .rsp_stb_o    (rsp_stb),
    .rsp_status_o (rsp_status),
    .rsp_data_o   (rsp_data)
  );

  // reply starts 3 edges after last request word
  reply_frame_encoder reply_frame_encoder_inst (
    .clk40        (clk40),
    .arst_n_i     (arst_n_i),
    .rsp_stb_i    (rsp_stb),
    .rsp_status_i (rsp_status),
    .rsp_data_i   (rsp_data),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_word_o   (rsp_word_o)
  );

endmodule

// File: source/reply_frame_encoder.sv
`timescale 1ns/1ps

module reply_frame_encoder (
  input  logic                    clk40,
  input  logic                    arst_n_i,
  input  logic                    rsp_stb_i,
  input  gem_link_pkg::payload_t  rsp_status_i,
  input  gem_link_pkg::reg_data_t rsp_data_i,
  output logic                    rsp_valid_o,
  output gem_link_pkg::payload_t  rsp_word_o
);

  // --------------------------------------------------
  // local constants
  // --------------------------------------------------

  localparam int PAYLOAD_W = $bits(gem_link_pkg::payload_t);
  localparam int DATA_W    = $bits(gem_link_pkg::reg_data_t);
  localparam int STAT_HI_W = PAYLOAD_W - 2; // status bits kept in word 2
  localparam int SR_W      = STAT_HI_W + DATA_W; // words 2 to 7
  localparam int CNT_W     = $clog2(gem_link_pkg::RSP_WORDS + 1);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(gem_link_pkg::RSP_WORDS);

  logic [SR_W-1:0]  word_sr;  // remaining reply words, msb first
  logic [CNT_W-1:0] word_cnt; // words already put out

  // --------------------------------------------------
  // word sequencing
  // --------------------------------------------------

  // word 2 packs status[5:2] with data[31:30], status[1:0] are zero anyway
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_word_o  <= '0;
      word_cnt    <= '0;
    end else if (rsp_stb_i) begin
      rsp_valid_o <= 1'b1;
      rsp_word_o  <= gem_link_pkg::FRAME_START; // first word
      word_cnt    <= CNT_W'(1);
    end else if (rsp_valid_o) begin
      if (word_cnt == CNT_LAST) begin
        rsp_valid_o <= 1'b0; // frame done
        rsp_word_o  <= '0;   // idle is zero
        word_cnt    <= '0;
      end else begin
        rsp_word_o <= word_sr[SR_W-1 -: PAYLOAD_W];
        word_cnt   <= word_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // payload shift register
  // --------------------------------------------------

  always_ff @(posedge clk40) begin
    if (rsp_stb_i) begin
      word_sr <= {rsp_status_i[PAYLOAD_W-1 -: STAT_HI_W], rsp_data_i};
    end else if (rsp_valid_o) begin
      word_sr <= word_sr << PAYLOAD_W; // next 6-bit group up
    end
  end

endmodule

// File: source/ctrl_reg_bank.sv
`timescale 1ns/1ps

module ctrl_reg_bank #(
  parameter int NUM_REGS = 16
) (
  input  logic                    clk40,
  input  logic                    arst_n_i,
  input  logic                    req_stb_i,
  input  logic                    req_we_i,
  input  gem_link_pkg::reg_addr_t req_addr_i,
  input  gem_link_pkg::reg_data_t req_data_i,
  output logic                    rsp_stb_o,
  output gem_link_pkg::payload_t  rsp_status_o,
  output gem_link_pkg::reg_data_t rsp_data_o
);

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
  localparam int LIM_W = $bits(gem_link_pkg::reg_addr_t) + 1; // room for 65536
  localparam logic [LIM_W-1:0] REG_LIMIT = LIM_W'(NUM_REGS);

  gem_link_pkg::reg_data_t regs [NUM_REGS]; // reg 0 doubles as loopback
  logic                    in_range;
  logic [IDX_W-1:0]        idx;
  gem_link_pkg::payload_t  status;

  assign in_range = {1'b0, req_addr_i} < REG_LIMIT;
  assign idx      = req_addr_i[IDX_W-1:0];

  always_comb begin
    status                             = '0;
    status[gem_link_pkg::STAT_ACK_BIT] = 1'b1;      // always acked
    status[gem_link_pkg::STAT_WR_BIT]  = req_we_i;
    status[gem_link_pkg::STAT_ERR_BIT] = ~in_range;
  end

  // --------------------------------------------------
  // register storage
  // --------------------------------------------------

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (req_stb_i && req_we_i && in_range) begin
      regs[idx] <= req_data_i;
    end
  end

  // --------------------------------------------------
  // response
  // --------------------------------------------------

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) rsp_stb_o <= 1'b0;
    else           rsp_stb_o <= req_stb_i; // one cycle behind request
  end

  always_ff @(posedge clk40) begin
    if (req_stb_i) begin
      rsp_status_o <= status;
      if (!in_range)     rsp_data_o <= '0;         // bad address
      else if (req_we_i) rsp_data_o <= req_data_i; // write echo
      else               rsp_data_o <= regs[idx];
    end
  end

endmodule

// File: source/gbt_frame_decoder.sv
`timescale 1ns/1ps

module gbt_frame_decoder (
  input  logic                   clk40,
  input  logic                   arst_n_i,
  input  gem_link_pkg::gbt_word_t gbt_word_i,
  output logic                   req_stb_o,
  output logic                   req_we_o,
  output gem_link_pkg::reg_addr_t req_addr_o,
  output gem_link_pkg::reg_data_t req_data_o
);

  // --------------------------------------------------
  // local constants
  // --------------------------------------------------

  localparam int PAYLOAD_W = $bits(gem_link_pkg::payload_t);
  localparam int ADDR_W    = $bits(gem_link_pkg::reg_addr_t);
  localparam int DATA_W    = $bits(gem_link_pkg::reg_data_t);
  localparam int FIELD_W   = ADDR_W + DATA_W; // 48 bits over 8 words
  localparam int POS_W     = $clog2(gem_link_pkg::REQ_WORDS);

  localparam int WR_VALID_BIT = 5; // begin word
  localparam int WR_EN_BIT    = 4;

  // position of last address word, counted from the start word
  localparam logic [POS_W-1:0] POS_ADDR_LAST = POS_W'(4);
  localparam logic [POS_W-1:0] POS_LAST      = POS_W'(gem_link_pkg::REQ_WORDS - 1);

  typedef enum logic [1:0] {
    ST_HUNT,  // waiting for 0x2A
    ST_BEGIN, // valid / write enable word
    ST_ADDR,  // 3 address words
    ST_DATA   // 5 data words
  } dec_state_t;

  dec_state_t               state;
  logic [POS_W-1:0]         pos_cnt;   // word position inside frame
  gem_link_pkg::payload_t   payload;
  logic [FIELD_W-1:0]       field_sr;  // addr and data shifted in msb first
  logic [FIELD_W-1:0]       field_nxt;
  logic                     we_q;

  // flag bits are not ours
  assign payload   = gbt_word_i[PAYLOAD_W-1:0];
  assign field_nxt = {field_sr[FIELD_W-PAYLOAD_W-1:0], payload};

  // --------------------------------------------------
  // frame tracking
  // --------------------------------------------------

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state     <= ST_HUNT;
      pos_cnt   <= '0;
      req_stb_o <= 1'b0;
    end else begin
      req_stb_o <= 1'b0; // single cycle strobe
      case (state)
        ST_HUNT: begin
          if (payload == gem_link_pkg::FRAME_START) begin
            state   <= ST_BEGIN;
            pos_cnt <= POS_W'(1);
          end
        end
        ST_BEGIN: begin
          if (payload[WR_VALID_BIT]) begin
            state   <= ST_ADDR;
            pos_cnt <= pos_cnt + 1'b1;
          end else begin
            state   <= ST_HUNT; // invalid request, drop it
            pos_cnt <= '0;
          end
        end
        ST_ADDR: begin
          pos_cnt <= pos_cnt + 1'b1;
          if (pos_cnt == POS_ADDR_LAST) state <= ST_DATA;
        end
        ST_DATA: begin
          // 0x2A in here is plain data, no restart
          if (pos_cnt == POS_LAST) begin
            state     <= ST_HUNT;
            pos_cnt   <= '0;
            req_stb_o <= 1'b1;
          end else begin
            pos_cnt <= pos_cnt + 1'b1;
          end
        end
        default: begin
          state   <= ST_HUNT;
          pos_cnt <= '0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // field assembly
  // --------------------------------------------------

  always_ff @(posedge clk40) begin
    if (state == ST_BEGIN) we_q <= payload[WR_EN_BIT];
    if (state == ST_ADDR || state == ST_DATA) field_sr <= field_nxt;
    // last data word, outputs hold until next request
    if (state == ST_DATA && pos_cnt == POS_LAST) begin
      req_we_o   <= we_q;
      req_addr_o <= field_nxt[FIELD_W-1:DATA_W];
      req_data_o <= field_nxt[DATA_W-1:0];
    end
  end

endmodule

// File: source/gem_link_pkg.sv
package gem_link_pkg;

  // --------------------------------------------------
  // link word and field widths
  // --------------------------------------------------

  // one word per clk40, upper 4 bits are ttc flags
  typedef logic [9:0] gbt_word_t;

  // 6-bit payload, used for request and reply words alike
  typedef logic [5:0] payload_t;

  typedef logic [15:0] reg_addr_t; // request address
  typedef logic [31:0] reg_data_t; // register data

  // --------------------------------------------------
  // frame constants
  // --------------------------------------------------

  // marks start of request and reply frames
  localparam payload_t FRAME_START = 6'h2A;

  localparam int REQ_WORDS = 10; // start, begin, 3 addr, 5 data
  localparam int RSP_WORDS = 7;  // start, status, 5 data

  // --------------------------------------------------
  // reply status payload
  // --------------------------------------------------

  // remaining status bits stay zero
  localparam int STAT_ACK_BIT = 5; // request seen
  localparam int STAT_WR_BIT  = 4; // copy of write enable
  localparam int STAT_ERR_BIT = 3; // address out of range

endpackage
